/* mmu_pkg.sv */
package mmu_pkg;

    localparam int ADDR_W = 32;
    localparam int VPN_W = 20;
    localparam int PFN_W = 20;
    localparam int OFFSET_W = ADDR_W - VPN_W; // 4 KB pages

    localparam int TLB_DEPTH = 8;
    localparam int TLB_IDX_W = $clog2(TLB_DEPTH);

    localparam int CATTR_W = 3; // Bit 0 clear means uncached
    localparam int SEG_SEL_W = 3; // Top address bits that select the segment

    typedef enum logic [1:0] {
        SEG_KUSEG = 2'd0, // 0x0000_0000 to 0x7fff_ffff, mapped
        SEG_KSEG0 = 2'd1, // 0x8000_0000 to 0x9fff_ffff, unmapped
        SEG_KSEG1 = 2'd2, // 0xa000_0000 to 0xbfff_ffff, unmapped and uncached
        SEG_KSEG23 = 2'd3 // 0xc000_0000 and up, mapped
    } seg_e;

    typedef enum logic {
        ACC_DATA = 1'b0,
        ACC_FETCH = 1'b1
    } access_e;

    typedef enum logic [1:0] {
        FAULT_NONE = 2'd0,
        FAULT_ADDR_ERR = 2'd1,
        FAULT_TLB_MISS = 2'd2
    } fault_e;

endpackage

/* mmu_resp.sv */
module mmu_resp import mmu_pkg::*; (
    input logic clk,
    input logic reset_i,

    input logic kseg0_uncached_i,
    mmu_stage_if.resp_mp dec_i,

    input logic tlb_hit_i,
    input logic [PFN_W-1:0] tlb_pfn_i,
    input logic [CATTR_W-1:0] tlb_cattr_i,

    output logic resp_valid_o,
    output access_e resp_access_o,
    output logic [ADDR_W-1:0] resp_paddr_o,
    output logic resp_uncached_o,
    output logic resp_mapped_o,
    output fault_e resp_fault_o
);

    logic [ADDR_W-1:0] paddr_d;
    logic uncached_d;
    logic mapped_d;
    fault_e fault_d;

    always_comb begin
        paddr_d = '0;
        uncached_d = 1'b0;
        mapped_d = 1'b0;
        fault_d = FAULT_NONE;
        if (dec_i.addr_err) begin
            fault_d = FAULT_ADDR_ERR; // Beats any TLB result
        end else begin
            case (dec_i.seg)
                SEG_KSEG1: begin
                    paddr_d = dec_i.unmapped_paddr;
                    uncached_d = 1'b1;
                end
                SEG_KSEG0: begin
                    paddr_d = dec_i.unmapped_paddr;
                    uncached_d = kseg0_uncached_i; // CP0 level at this stage
                end
                default: begin
                    mapped_d = 1'b1;
                    if (tlb_hit_i) begin
                        paddr_d = {tlb_pfn_i, dec_i.vaddr[OFFSET_W-1:0]};
                        uncached_d = ~tlb_cattr_i[0];
                    end else begin
                        fault_d = FAULT_TLB_MISS;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            resp_valid_o <= 1'b0;
        end else begin
            resp_valid_o <= dec_i.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (dec_i.valid) begin
            resp_access_o <= dec_i.access;
            resp_paddr_o <= paddr_d;
            resp_uncached_o <= uncached_d;
            resp_mapped_o <= mapped_d;
            resp_fault_o <= fault_d;
        end
    end

endmodule

/* mmu_seg_decode.sv */
module mmu_seg_decode import mmu_pkg::*; (
    input logic clk,
    input logic reset_i,

    input logic req_valid_i,
    input logic [ADDR_W-1:0] req_addr_i,
    input access_e req_access_i,
    input logic user_mode_i,

    mmu_stage_if.dec_mp dec_o
);

    logic [SEG_SEL_W-1:0] seg_sel;
    seg_e seg_d;

    logic valid_q;
    access_e access_q;
    logic [ADDR_W-1:0] vaddr_q;
    seg_e seg_q;
    logic addr_err_q;
    logic [ADDR_W-1:0] paddr_q;

    assign seg_sel = req_addr_i[ADDR_W-1 -: SEG_SEL_W];

    always_comb begin
        case (seg_sel)
            3'b100: seg_d = SEG_KSEG0;
            3'b101: seg_d = SEG_KSEG1;
            3'b110,
            3'b111: seg_d = SEG_KSEG23;
            default: seg_d = SEG_KUSEG; // Bit 31 clear
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= req_valid_i; // One cycle strobe, no stall
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid_i) begin
            access_q <= req_access_i;
            vaddr_q <= req_addr_i;
            seg_q <= seg_d;
            addr_err_q <= user_mode_i & req_addr_i[ADDR_W-1]; // Upper half is kernel only
            paddr_q <= {{SEG_SEL_W{1'b0}}, req_addr_i[ADDR_W-SEG_SEL_W-1:0]};
        end
    end

    assign dec_o.valid = valid_q;
    assign dec_o.access = access_q;
    assign dec_o.vaddr = vaddr_q;
    assign dec_o.seg = seg_q;
    assign dec_o.addr_err = addr_err_q;
    assign dec_o.unmapped_paddr = paddr_q;

endmodule

/* mmu_stage_if.sv */
interface mmu_stage_if import mmu_pkg::*; ();

    logic valid;
    access_e access;
    logic [ADDR_W-1:0] vaddr;
    seg_e seg;
    logic addr_err;
    logic [ADDR_W-1:0] unmapped_paddr;

    modport dec_mp (
        output valid,
        output access,
        output vaddr,
        output seg,
        output addr_err,
        output unmapped_paddr
    );

    modport resp_mp (
        input valid,
        input access,
        input vaddr,
        input seg,
        input addr_err,
        input unmapped_paddr
    );

endinterface

/* mmu_tlb.sv */
module mmu_tlb import mmu_pkg::*; (
    input logic clk,
    input logic reset_i,

    input logic we_i,
    input logic [TLB_IDX_W-1:0] widx_i,
    input logic [VPN_W-1:0] wvpn_i,
    input logic [PFN_W-1:0] wpfn_i,
    input logic [CATTR_W-1:0] wcattr_i,

    input logic [VPN_W-1:0] lvpn_i,
    output logic hit_o,
    output logic [PFN_W-1:0] pfn_o,
    output logic [CATTR_W-1:0] cattr_o
);

    logic [TLB_DEPTH-1:0] valid_q;
    logic [VPN_W-1:0] vpn_q [TLB_DEPTH];
    logic [PFN_W-1:0] pfn_q [TLB_DEPTH];
    logic [CATTR_W-1:0] cattr_q [TLB_DEPTH];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q <= '0;
        end else if (we_i) begin
            valid_q[widx_i] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (we_i) begin
            vpn_q[widx_i] <= wvpn_i;
            pfn_q[widx_i] <= wpfn_i;
            cattr_q[widx_i] <= wcattr_i;
        end
    end

    // Scan from the top entry down so the lowest matching index is the
    // last one assigned and wins when several entries share a VPN
    always_comb begin
        hit_o = 1'b0;
        pfn_o = '0;
        cattr_o = '0;
        for (int i = TLB_DEPTH - 1; i >= 0; i--) begin
            if (valid_q[i] && (vpn_q[i] == lvpn_i)) begin
                hit_o = 1'b1;
                pfn_o = pfn_q[i];
                cattr_o = cattr_q[i];
            end
        end
    end

endmodule

/* mmu_top.sv */
module mmu_top import mmu_pkg::*; (
    input logic clk,
    input logic reset_i,

    input logic req_valid_i,
    input logic [ADDR_W-1:0] req_addr_i,
    input access_e req_access_i,
    input logic user_mode_i,
    input logic kseg0_uncached_i,

    input logic tlb_we_i,
    input logic [TLB_IDX_W-1:0] tlb_idx_i,
    input logic [VPN_W-1:0] tlb_vpn_i,
    input logic [PFN_W-1:0] tlb_pfn_i,
    input logic [CATTR_W-1:0] tlb_cattr_i,

    output logic resp_valid_o,
    output access_e resp_access_o,
    output logic [ADDR_W-1:0] resp_paddr_o,
    output logic resp_uncached_o,
    output logic resp_mapped_o,
    output fault_e resp_fault_o
);

    mmu_stage_if stage_if ();

    logic lookup_hit;
    logic [PFN_W-1:0] lookup_pfn;
    logic [CATTR_W-1:0] lookup_cattr;

    mmu_seg_decode i_seg_decode (
        .clk (clk),
        .reset_i (reset_i),
        .req_valid_i (req_valid_i),
        .req_addr_i (req_addr_i),
        .req_access_i (req_access_i),
        .user_mode_i (user_mode_i),
        .dec_o (stage_if.dec_mp)
    );

    mmu_tlb i_tlb (
        .clk (clk),
        .reset_i (reset_i),
        .we_i (tlb_we_i),
        .widx_i (tlb_idx_i),
        .wvpn_i (tlb_vpn_i),
        .wpfn_i (tlb_pfn_i),
        .wcattr_i (tlb_cattr_i),
        .lvpn_i (stage_if.vaddr[ADDR_W-1 -: VPN_W]), // Looked up in the second stage
        .hit_o (lookup_hit),
        .pfn_o (lookup_pfn),
        .cattr_o (lookup_cattr)
    );

    mmu_resp i_resp (
        .clk (clk),
        .reset_i (reset_i),
        .kseg0_uncached_i (kseg0_uncached_i),
        .dec_i (stage_if.resp_mp),
        .tlb_hit_i (lookup_hit),
        .tlb_pfn_i (lookup_pfn),
        .tlb_cattr_i (lookup_cattr),
        .resp_valid_o (resp_valid_o),
        .resp_access_o (resp_access_o),
        .resp_paddr_o (resp_paddr_o),
        .resp_uncached_o (resp_uncached_o),
        .resp_mapped_o (resp_mapped_o),
        .resp_fault_o (resp_fault_o)
    );

endmodule

/* tb_mmu.sv */
module tb_mmu import mmu_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD = 8;
    localparam int RESET_CYCLES = 16;
    localparam int BATCH = 24;
    localparam int LONG_BATCH = 64;
    localparam int TEST_CYCLES = 4 + 6 * BATCH + LONG_BATCH + 7 * 2 + 1 + TLB_DEPTH + 3;

    typedef struct packed {
        access_e access;
        logic [ADDR_W-1:0] paddr;
        logic uncached;
        logic mapped;
        fault_e fault;
    } resp_t;

    logic clk;
    logic reset_i;
    logic req_valid_i;
    logic [ADDR_W-1:0] req_addr_i;
    access_e req_access_i;
    logic user_mode_i;
    logic kseg0_uncached_i;
    logic tlb_we_i;
    logic [TLB_IDX_W-1:0] tlb_idx_i;
    logic [VPN_W-1:0] tlb_vpn_i;
    logic [PFN_W-1:0] tlb_pfn_i;
    logic [CATTR_W-1:0] tlb_cattr_i;
    logic resp_valid_o;
    access_e resp_access_o;
    logic [ADDR_W-1:0] resp_paddr_o;
    logic resp_uncached_o;
    logic resp_mapped_o;
    fault_e resp_fault_o;

    logic [31:0] rng_state = 32'd8;
    logic [1:0] valid_hist; // Bit 1 holds the request issued two cycles ago
    resp_t exp_q [$];
    logic shadow_valid [TLB_DEPTH];
    logic [VPN_W-1:0] shadow_vpn [TLB_DEPTH];
    logic [PFN_W-1:0] shadow_pfn [TLB_DEPTH];
    logic [CATTR_W-1:0] shadow_cattr [TLB_DEPTH];
    logic [VPN_W-1:0] retired_vpn [$]; // VPNs that were overwritten and should miss

    mmu_top i_mmu_top (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #((RESET_CYCLES + TEST_CYCLES + 20) * CLK_PERIOD);
        $display("Timeout: the run did not finish in the expected number of cycles");
        $display("Test failed");
        $fatal(1, "Watchdog expired");
    end

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rng_state = x;
        return x;
    endfunction

    function automatic logic [ADDR_W-1:0] pick_mapped();
        logic [31:0] r;
        logic [ADDR_W-1:0] a;
        logic [TLB_IDX_W-1:0] idx;
        r = next_rand();
        a = next_rand();
        idx = r[4:2];
        if (a[31:30] == 2'b10) begin
            a[30] = 1'b1; // Move kseg0/1 up to kseg2/3
        end
        if (r[1] == 1'b0 && shadow_valid[idx]) begin
            a[ADDR_W-1 -: VPN_W] = shadow_vpn[idx];
        end else if (r[1:0] == 2'b10 && retired_vpn.size() > 0) begin
            a[ADDR_W-1 -: VPN_W] = retired_vpn[r[9:5] % retired_vpn.size()];
        end
        return a;
    endfunction

    function automatic logic [ADDR_W-1:0] pick_unmapped();
        logic [ADDR_W-1:0] a;
        a = next_rand();
        a[31:30] = 2'b10; // Bit 29 picks kseg0 or kseg1
        return a;
    endfunction

    function automatic logic [ADDR_W-1:0] pick_any();
        logic [31:0] r;
        r = next_rand();
        if (r[0]) begin
            return pick_mapped();
        end
        return pick_unmapped();
    endfunction

    function automatic resp_t model_resp(input logic [ADDR_W-1:0] addr, input access_e acc,
                                         input logic user, input logic k0_uncached);
        resp_t m;
        logic hit;
        m = '0;
        m.access = acc;
        m.fault = FAULT_NONE;
        hit = 1'b0;
        if (user && addr[31]) begin
            m.fault = FAULT_ADDR_ERR;
        end else if (addr[31:29] == 3'b101) begin
            m.paddr = {3'b000, addr[28:0]};
            m.uncached = 1'b1;
        end else if (addr[31:29] == 3'b100) begin
            m.paddr = {3'b000, addr[28:0]};
            m.uncached = k0_uncached;
        end else begin
            m.mapped = 1'b1;
            for (int i = 0; i < TLB_DEPTH; i++) begin
                if (!hit && shadow_valid[i] && shadow_vpn[i] == addr[31:12]) begin
                    hit = 1'b1;
                    m.paddr = {shadow_pfn[i], addr[11:0]};
                    m.uncached = ~shadow_cattr[i][0];
                end
            end
            if (!hit) begin
                m.fault = FAULT_TLB_MISS;
            end
        end
        return m;
    endfunction

    task automatic report_mismatch(input string name, input logic [ADDR_W-1:0] exp,
                                   input logic [ADDR_W-1:0] act);
        $display("CHECK FAILED at time %0t: %s expected 0x%0h, actual 0x%0h", $time, name, exp, act);
        $display("Test failed");
        $fatal(1, "Stopping at the first mismatch");
    endtask

    task automatic check_outputs();
        resp_t exp;
        assert (resp_valid_o === valid_hist[1])
            else report_mismatch("resp_valid_o", valid_hist[1], resp_valid_o);
        if (valid_hist[1]) begin
            exp = exp_q.pop_front();
            assert (resp_access_o === exp.access)
                else report_mismatch("resp_access_o", exp.access, resp_access_o);
            assert (resp_paddr_o === exp.paddr)
                else report_mismatch("resp_paddr_o", exp.paddr, resp_paddr_o);
            assert (resp_uncached_o === exp.uncached)
                else report_mismatch("resp_uncached_o", exp.uncached, resp_uncached_o);
            assert (resp_mapped_o === exp.mapped)
                else report_mismatch("resp_mapped_o", exp.mapped, resp_mapped_o);
            assert (resp_fault_o === exp.fault)
                else report_mismatch("resp_fault_o", exp.fault, resp_fault_o);
        end
    endtask

    // Checks the outputs of the last cycle, then leaves the inputs idle
    task automatic next_cycle();
        @(negedge clk);
        check_outputs();
        req_valid_i = 1'b0;
        tlb_we_i = 1'b0;
        valid_hist[1] = valid_hist[0];
        valid_hist[0] = 1'b0;
    endtask

    task automatic request(input logic [ADDR_W-1:0] addr, input logic user);
        access_e acc;
        logic [31:0] r;
        r = next_rand();
        acc = access_e'(r[0]);
        next_cycle();
        req_valid_i = 1'b1;
        req_addr_i = addr;
        req_access_i = acc;
        user_mode_i = user;
        valid_hist[0] = 1'b1;
        exp_q.push_back(model_resp(addr, acc, user, kseg0_uncached_i));
    endtask

    task automatic write_entry(input logic [TLB_IDX_W-1:0] idx);
        logic [31:0] r;
        logic [VPN_W-1:0] vpn;
        logic dup;
        do begin
            r = next_rand();
            vpn = r[31:12];
            if (vpn[19:18] == 2'b10) begin
                vpn[18] = 1'b1; // Keep the page in a mapped segment
            end
            dup = 1'b0;
            for (int i = 0; i < TLB_DEPTH; i++) begin
                if (shadow_valid[i] && shadow_vpn[i] == vpn) begin
                    dup = 1'b1;
                end
            end
        end while (dup);
        if (shadow_valid[idx]) begin
            retired_vpn.push_back(shadow_vpn[idx]);
        end
        r = next_rand();
        next_cycle();
        tlb_we_i = 1'b1;
        tlb_idx_i = idx;
        tlb_vpn_i = vpn;
        tlb_pfn_i = r[PFN_W-1:0];
        tlb_cattr_i = r[22:20];
        shadow_valid[idx] = 1'b1;
        shadow_vpn[idx] = vpn;
        shadow_pfn[idx] = r[PFN_W-1:0];
        shadow_cattr[idx] = r[22:20];
    endtask

    initial begin
        logic [31:0] r;
        reset_i = 1'b1;
        req_valid_i = 1'b0;
        req_addr_i = '0;
        req_access_i = ACC_DATA;
        user_mode_i = 1'b0;
        kseg0_uncached_i = 1'b0;
        tlb_we_i = 1'b0;
        tlb_idx_i = '0;
        tlb_vpn_i = '0;
        tlb_pfn_i = '0;
        tlb_cattr_i = '0;
        valid_hist = 2'b00;
        for (int i = 0; i < TLB_DEPTH; i++) begin
            shadow_valid[i] = 1'b0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;

        repeat (4) next_cycle(); // Quiet after reset
        repeat (BATCH) request(pick_mapped(), 1'b0); // Empty TLB, all misses
        repeat (2) next_cycle();

        repeat (BATCH) request(pick_unmapped(), 1'b0);
        repeat (2) next_cycle();
        next_cycle();
        kseg0_uncached_i = 1'b1;
        repeat (BATCH) request(pick_unmapped(), 1'b0);
        repeat (2) next_cycle();

        for (int i = 0; i < TLB_DEPTH; i++) begin
            write_entry(TLB_IDX_W'(i));
        end
        repeat (BATCH) request(pick_mapped(), 1'b0);
        repeat (2) next_cycle();
        repeat (3) write_entry(TLB_IDX_W'(next_rand())); // Overwrite live entries
        repeat (BATCH) request(pick_mapped(), 1'b0);
        repeat (2) next_cycle();

        repeat (BATCH) request(pick_any(), 1'b1); // User mode
        repeat (2) next_cycle();

        for (int i = 0; i < LONG_BATCH; i++) begin
            r = next_rand();
            request(pick_any(), r[7]);
        end
        repeat (2) next_cycle();

        if (exp_q.size() != 0) begin
            $display("%0d expected responses never arrived", exp_q.size());
            $display("Test failed");
            $fatal(1, "Responses missing at the end of the run");
        end else begin
            $display("Test passed");
            $finish;
        end
    end

endmodule

/* verilog.f */
mmu_pkg.sv
mmu_stage_if.sv
mmu_seg_decode.sv
mmu_tlb.sv
mmu_resp.sv
mmu_top.sv
tb_mmu.sv
